// File: rtl/core_defs.svh
// width, reset pc, memory depth and opcode macros for the rv64 core
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath widths
`define XLEN 64
`define INST_W 32
`define REG_ID_W 5

// instruction memory, word addressed
`define IMEM_WORDS 256
`define IMEM_AW 8

// first fetch address after reset
`define PC_RESET 64'h8000_0000

// major opcodes, inst[6:0]
`define OPC_OP_IMM 7'b0010011
`define OPC_OP 7'b0110011
`define OPC_AUIPC 7'b0010111
`define OPC_JAL 7'b1101111
// ecall/ebreak live here
`define OPC_SYSTEM 7'b1110011

`endif

// File: rtl/core_pkg.sv
// core_pkg with vector typedefs, alu operation enum and core state enum
`include "core_defs.svh"

package core_pkg;

  // register and data width
  typedef logic [`XLEN-1:0] xlen_t;

  // raw instruction word
  typedef logic [`INST_W-1:0] inst_t;

  // x0..x31
  typedef logic [`REG_ID_W-1:0] reg_id_t;

  // word index into instruction memory
  typedef logic [`IMEM_AW-1:0] imem_addr_t;

  // operations the alu knows
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // run until ebreak or an illegal encoding
  typedef enum logic [1:0] {
    ST_RUN,
    ST_HALT,
    ST_TRAP
  } core_state_e;

endpackage

// File: rtl/inst_mem.sv
// instruction memory with synchronous load port and combinational fetch
`timescale 1ns/1ps
`include "core_defs.svh"

module inst_mem (
  input  logic                 clk,
  // load port, driven from outside the core
  input  logic                 we,
  input  core_pkg::imem_addr_t waddr,
  input  core_pkg::inst_t      wdata,
  // fetch port
  input  core_pkg::imem_addr_t raddr,
  output core_pkg::inst_t      inst
);

  // program storage, no reset
  core_pkg::inst_t mem [`IMEM_WORDS];

  // load one word per edge
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // fetch is same cycle
  assign inst = mem[raddr];

endmodule

// File: rtl/decoder.sv
// rv64i subset decoder: fields, immediates, alu op and operand selects
`timescale 1ns/1ps
`include "core_defs.svh"

module decoder (
  input  core_pkg::inst_t   inst,
  output core_pkg::reg_id_t rd,
  output core_pkg::reg_id_t rs1,
  output core_pkg::reg_id_t rs2,
  output core_pkg::xlen_t   imm,
  output core_pkg::alu_op_e alu_op,
  output logic              use_imm,
  output logic              use_pc,
  output logic              is_jal,
  output logic              is_ebreak,
  output logic              illegal,
  output logic              reg_write
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  core_pkg::xlen_t   imm_i;
  core_pkg::xlen_t   imm_u;
  core_pkg::xlen_t   imm_j;
  // funct3 lookup shared by op and op-imm
  core_pkg::alu_op_e f3_op;
  logic              f3_ok;
  logic              ebreak_enc;

  // fixed field positions
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // sign-extended immediates
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  // u type: upper 20 bits, low 12 zero, then extend from bit 31
  assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'h000};
  // j type, scrambled offset, bit 0 always 0
  assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // only the exact ebreak word, other system encodings trap
  assign ebreak_enc = (inst[31:20] == 12'h001) && (inst[19:7] == '0);

  // funct3 to alu op, shifts are not supported
  always_comb begin
    f3_ok = 1'b1;
    unique case (funct3)
      3'b000: f3_op = core_pkg::ALU_ADD;
      3'b010: f3_op = core_pkg::ALU_SLT;
      3'b011: f3_op = core_pkg::ALU_SLTU;
      3'b100: f3_op = core_pkg::ALU_XOR;
      3'b110: f3_op = core_pkg::ALU_OR;
      3'b111: f3_op = core_pkg::ALU_AND;
      default: begin
        f3_op = core_pkg::ALU_ADD;
        f3_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    // defaults: no write, register operands
    imm       = imm_i;
    alu_op    = core_pkg::ALU_ADD;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    is_jal    = 1'b0;
    is_ebreak = 1'b0;
    illegal   = 1'b0;
    reg_write = 1'b0;
    case (opcode)
      `OPC_OP_IMM: begin
        use_imm   = 1'b1;
        alu_op    = f3_op;
        illegal   = !f3_ok;
        reg_write = f3_ok;
      end
      `OPC_OP: begin
        if ((funct7 == 7'b0000000) && f3_ok) begin
          alu_op    = f3_op;
          reg_write = 1'b1;
        end else if ((funct7 == 7'b0100000) && (funct3 == 3'b000)) begin
          // sub is the only alternate encoding here
          alu_op    = core_pkg::ALU_SUB;
          reg_write = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      `OPC_AUIPC: begin
        // pc + u-imm through the adder
        imm       = imm_u;
        use_pc    = 1'b1;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      `OPC_JAL: begin
        // link value comes from the top, alu unused
        imm       = imm_j;
        is_jal    = 1'b1;
        reg_write = 1'b1;
      end
      `OPC_SYSTEM: begin
        is_ebreak = ebreak_enc;
        illegal   = !ebreak_enc;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

// File: rtl/register_file.sv
// 32 x 64-bit register file, two async reads, one sync write, x0 zero
`timescale 1ns/1ps
`include "core_defs.svh"

module register_file (
  input  logic              clk,
  input  logic              we,
  input  core_pkg::reg_id_t waddr,
  input  core_pkg::xlen_t   wdata,
  input  core_pkg::reg_id_t raddr_1,
  input  core_pkg::reg_id_t raddr_2,
  output core_pkg::xlen_t   rdata_1,
  output core_pkg::xlen_t   rdata_2
);

  // x1..x31 only, x0 has no storage
  core_pkg::xlen_t regs [1:(1 << `REG_ID_W) - 1];

  // writes to x0 are dropped here
  always_ff @(posedge clk) begin
    if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // read port 1
  always_comb begin
    rdata_1 = '0;
    if (raddr_1 != '0) begin
      rdata_1 = regs[raddr_1];
    end
  end

  // read port 2
  always_comb begin
    rdata_2 = '0;
    if (raddr_2 != '0) begin
      rdata_2 = regs[raddr_2];
    end
  end

endmodule

// File: rtl/alu.sv
// 64-bit alu: add, sub, xor, or, and, slt, sltu
`timescale 1ns/1ps
`include "core_defs.svh"

module alu (
  input  core_pkg::xlen_t   operand_1,
  input  core_pkg::xlen_t   operand_2,
  input  core_pkg::alu_op_e op,
  output core_pkg::xlen_t   result
);

  logic lt_signed;
  logic lt_unsigned;

  // both compares always computed
  assign lt_signed   = $signed(operand_1) < $signed(operand_2);
  assign lt_unsigned = operand_1 < operand_2;

  always_comb begin
    unique case (op)
      core_pkg::ALU_ADD:  result = operand_1 + operand_2;
      core_pkg::ALU_SUB:  result = operand_1 - operand_2;
      core_pkg::ALU_XOR:  result = operand_1 ^ operand_2;
      core_pkg::ALU_OR:   result = operand_1 | operand_2;
      core_pkg::ALU_AND:  result = operand_1 & operand_2;
      // compares give 0 or 1
      core_pkg::ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt_signed};
      core_pkg::ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      default:            result = '0;
    endcase
  end

endmodule

// File: rtl/core_top.sv
// single-cycle core top: pc, next-pc and writeback selects, run/halt state
`timescale 1ns/1ps
`include "core_defs.svh"

module core_top (
  input  logic                 clk,
  input  logic                 reset,
  // instruction memory load
  input  logic                 imem_we,
  input  core_pkg::imem_addr_t imem_addr,
  input  core_pkg::inst_t      imem_wdata,
  // retirement view
  output core_pkg::xlen_t      pc,
  output logic                 retire_valid,
  output logic                 wb_en,
  output core_pkg::reg_id_t    wb_rd,
  output core_pkg::xlen_t      wb_data,
  output logic                 halted,
  output logic                 illegal
);

  core_pkg::core_state_e state;
  logic                  run;
  core_pkg::xlen_t       pc_offset;
  core_pkg::imem_addr_t  fetch_addr;
  core_pkg::inst_t       inst;
  core_pkg::reg_id_t     rd;
  core_pkg::reg_id_t     rs1;
  core_pkg::reg_id_t     rs2;
  core_pkg::xlen_t       imm;
  core_pkg::alu_op_e     alu_op;
  logic                  use_imm;
  logic                  use_pc;
  logic                  is_jal;
  logic                  is_ebreak;
  logic                  dec_illegal;
  logic                  reg_write;
  core_pkg::xlen_t       rdata_1;
  core_pkg::xlen_t       rdata_2;
  core_pkg::xlen_t       operand_1;
  core_pkg::xlen_t       operand_2;
  core_pkg::xlen_t       alu_result;
  core_pkg::xlen_t       pc_plus_4;
  core_pkg::xlen_t       next_pc;

  // word index relative to the reset pc
  assign pc_offset  = pc - `PC_RESET;
  assign fetch_addr = pc_offset[`IMEM_AW+1:2];

  inst_mem u_inst_mem (
    .clk   (clk),
    .we    (imem_we),
    .waddr (imem_addr),
    .wdata (imem_wdata),
    .raddr (fetch_addr),
    .inst  (inst)
  );

  decoder u_decoder (
    .inst      (inst),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .use_pc    (use_pc),
    .is_jal    (is_jal),
    .is_ebreak (is_ebreak),
    .illegal   (dec_illegal),
    .reg_write (reg_write)
  );

  register_file u_register_file (
    .clk     (clk),
    .we      (wb_en),
    .waddr   (wb_rd),
    .wdata   (wb_data),
    .raddr_1 (rs1),
    .raddr_2 (rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // pc for auipc, immediate for op-imm and auipc
  assign operand_1 = use_pc ? pc : rdata_1;
  assign operand_2 = use_imm ? imm : rdata_2;

  alu u_alu (
    .operand_1 (operand_1),
    .operand_2 (operand_2),
    .op        (alu_op),
    .result    (alu_result)
  );

  assign pc_plus_4 = pc + 64'd4;
  // jal is the only control transfer
  assign next_pc   = is_jal ? (pc + imm) : pc_plus_4;

  // nothing retires during reset or once stopped
  assign run          = (state == core_pkg::ST_RUN) && !reset;
  assign retire_valid = run && !dec_illegal;

  // x0 writes never show as a writeback
  assign wb_en   = run && reg_write && (rd != '0);
  assign wb_rd   = rd;
  assign wb_data = is_jal ? pc_plus_4 : alu_result;

  // sticky status, cleared only by reset
  assign halted  = !reset && (state != core_pkg::ST_RUN);
  assign illegal = !reset && (state == core_pkg::ST_TRAP);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= `PC_RESET;
      state <= core_pkg::ST_RUN;
    end else if (state == core_pkg::ST_RUN) begin
      if (dec_illegal) begin
        // trap, pc stays on the offending word
        state <= core_pkg::ST_TRAP;
      end else begin
        pc <= next_pc;
        if (is_ebreak) begin
          state <= core_pkg::ST_HALT;
        end
      end
    end
  end

endmodule

// File: dv/core_tb.sv
// core_tb with program tables, reference model, check task and timeout
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb;

  // operation kinds used by the program table
  localparam int K_ADD = 0;
  localparam int K_SUB = 1;
  localparam int K_XOR = 2;
  localparam int K_OR = 3;
  localparam int K_AND = 4;
  localparam int K_SLT = 5;
  localparam int K_SLTU = 6;
  localparam int K_ADDI = 7;
  localparam int K_XORI = 8;
  localparam int K_ORI = 9;
  localparam int K_ANDI = 10;
  localparam int K_SLTI = 11;
  localparam int K_SLTIU = 12;
  localparam int K_AUIPC = 13;
  localparam int K_JAL = 14;
  localparam int K_EBREAK = 15;
  localparam int K_ILL = 16;

  logic        clk;
  logic        reset;
  logic        imem_we;
  logic [7:0]  imem_addr;
  logic [31:0] imem_wdata;
  logic [63:0] pc;
  logic        retire_valid;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [63:0] wb_data;
  logic        halted;
  logic        illegal;

  // program table
  int          op_kind[$];
  int          op_rd[$];
  int          op_rs1[$];
  int          op_rs2[$];
  logic [31:0] op_imm[$];
  // expected retirements
  logic [63:0] exp_pc[$];
  logic        exp_wb_en[$];
  logic [4:0]  exp_rd[$];
  logic [63:0] exp_data[$];
  logic [63:0] end_pc;
  logic [63:0] model_regs[32];
  logic [31:0] lcg_state;
  int          errors;
  bit          timed_out;

  core_top u_core_top (
    .clk          (clk),
    .reset        (reset),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .pc           (pc),
    .retire_valid (retire_valid),
    .wb_en        (wb_en),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .halted       (halted),
    .illegal      (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic add_op(input int kind, input int rd, input int rs1, input int rs2,
                        input logic [31:0] imm);
    op_kind.push_back(kind);
    op_rd.push_back(rd);
    op_rs1.push_back(rs1);
    op_rs2.push_back(rs2);
    op_imm.push_back(imm);
  endtask

  // funct3 of the alu kinds for register and immediate forms alike
  function automatic logic [2:0] funct3_of(input int kind);
    case (kind)
      K_SLT, K_SLTI:   return 3'b010;
      K_SLTU, K_SLTIU: return 3'b011;
      K_XOR, K_XORI:   return 3'b100;
      K_OR, K_ORI:     return 3'b110;
      K_AND, K_ANDI:   return 3'b111;
      default:         return 3'b000;
    endcase
  endfunction

  function automatic logic [31:0] encode(input int idx);
    logic [31:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    imm = op_imm[idx];
    rd  = 5'(op_rd[idx]);
    rs1 = 5'(op_rs1[idx]);
    rs2 = 5'(op_rs2[idx]);
    f3  = funct3_of(op_kind[idx]);
    case (op_kind[idx])
      K_ADDI, K_XORI, K_ORI, K_ANDI, K_SLTI, K_SLTIU:
        return {imm[11:0], rs1, f3, rd, `OPC_OP_IMM};
      K_SUB:    return {7'b0100000, rs2, rs1, 3'b000, rd, `OPC_OP};
      K_AUIPC:  return {imm[19:0], rd, `OPC_AUIPC};
      K_JAL:    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
      K_EBREAK: return 32'h0010_0073;
      // load opcode is not part of the core
      K_ILL:    return 32'h0000_0003;
      default:  return {7'b0000000, rs2, rs1, f3, rd, `OPC_OP};
    endcase
  endfunction

  // reference model walks the op table in program order
  task automatic run_model();
    int          i;
    int          kind;
    logic [63:0] pcv;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] v;
    logic [63:0] next;
    bit          done;
    exp_pc.delete();
    exp_wb_en.delete();
    exp_rd.delete();
    exp_data.delete();
    foreach (model_regs[r]) model_regs[r] = '0;
    i = 0;
    done = 0;
    for (int step = 0; step < 64 && !done; step++) begin
      kind = op_kind[i];
      pcv  = `PC_RESET + 64'(4 * i);
      next = pcv + 64'd4;
      a    = model_regs[op_rs1[i]];
      // immediate forms take the sign-extended 12-bit value
      b    = (kind >= K_ADDI) ? {{52{op_imm[i][11]}}, op_imm[i][11:0]} : model_regs[op_rs2[i]];
      case (kind)
        K_ADD, K_ADDI:   v = a + b;
        K_SUB:           v = a - b;
        K_XOR, K_XORI:   v = a ^ b;
        K_OR, K_ORI:     v = a | b;
        K_AND, K_ANDI:   v = a & b;
        K_SLT, K_SLTI:   v = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        K_SLTU, K_SLTIU: v = (a < b) ? 64'd1 : 64'd0;
        K_AUIPC:         v = pcv + {{32{op_imm[i][19]}}, op_imm[i][19:0], 12'h000};
        default:         v = pcv + 64'd4;
      endcase
      if (kind == K_JAL) next = pcv + {{43{op_imm[i][20]}}, op_imm[i][20:0]};
      if (kind == K_ILL) begin
        // never retires and pc stays on it
        end_pc = pcv;
        done = 1;
      end else if (kind == K_EBREAK) begin
        exp_pc.push_back(pcv);
        exp_wb_en.push_back(1'b0);
        exp_rd.push_back('0);
        exp_data.push_back('0);
        end_pc = next;
        done = 1;
      end else begin
        exp_pc.push_back(pcv);
        exp_wb_en.push_back(op_rd[i] != 0);
        exp_rd.push_back(5'(op_rd[i]));
        exp_data.push_back(v);
        if (op_rd[i] != 0) model_regs[op_rd[i]] = v;
        i = int'((next - `PC_RESET) >> 2);
      end
    end
  endtask

  // load all words under reset
  // unused words get a nop tagged with the address
  task automatic load_program();
    @(posedge clk);
    #1;
    reset = 1'b1;
    for (int w = 0; w < `IMEM_WORDS; w++) begin
      @(posedge clk);
      #1;
      imem_we    = 1'b1;
      imem_addr  = 8'(w);
      imem_wdata = (w < op_kind.size()) ? encode(w) : {4'h0, 8'(w), 20'h00013};
    end
    @(posedge clk);
    #1;
    imem_we = 1'b0;
    repeat (4) begin
      @(posedge clk);
      #1;
    end
    check("pc", `PC_RESET, pc);
    check("retire_valid", 64'd0, 64'(retire_valid));
    reset = 1'b0;
    #1;
    check("pc", `PC_RESET, pc);
    check("halted", 64'd0, 64'(halted));
    check("illegal", 64'd0, 64'(illegal));
  endtask

  task automatic run_and_check(input logic exp_illegal);
    int idx;
    int cycles;
    int limit;
    idx    = 0;
    cycles = 0;
    limit  = op_kind.size() + exp_pc.size() + 20;
    while (idx < exp_pc.size() && cycles < limit) begin
      @(negedge clk);
      if (retire_valid) begin
        check("pc", exp_pc[idx], pc);
        check("wb_en", 64'(exp_wb_en[idx]), 64'(wb_en));
        if (exp_wb_en[idx]) begin
          check("wb_rd", 64'(exp_rd[idx]), 64'(wb_rd));
          check("wb_data", exp_data[idx], wb_data);
        end
        idx++;
      end
      cycles++;
    end
    if (idx < exp_pc.size()) begin
      $display("timeout: only %0d of %0d retirements seen", idx, exp_pc.size());
      errors++;
      timed_out = 1'b1;
    end else begin
      if (exp_illegal) begin
        // offending word sits at pc for one cycle without retiring
        @(negedge clk);
        check("retire_valid", 64'd0, 64'(retire_valid));
        check("pc", end_pc, pc);
      end
      // core must stay stopped
      repeat (6) begin
        @(negedge clk);
        check("retire_valid", 64'd0, 64'(retire_valid));
        check("halted", 64'd1, 64'(halted));
        check("illegal", 64'(exp_illegal), 64'(illegal));
        check("pc", end_pc, pc);
      end
    end
  endtask

  initial begin
    reset      = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    errors     = 0;
    timed_out  = 1'b0;
    lcg_state  = 32'hf3f0;

    // first program covers arithmetic, logic, compares, auipc, jal, x0 and ebreak
    // x1 positive and x2 negative so slt and sltu differ
    add_op(K_ADDI, 1, 0, 0, (lcg_next() >> 20) & 32'h7ff);
    add_op(K_ADDI, 2, 0, 0, (lcg_next() >> 20) | 32'h800);
    add_op(K_ADD, 3, 1, 2, 0);
    add_op(K_SUB, 4, 3, 1, 0);
    add_op(K_XOR, 5, 1, 2, 0);
    add_op(K_OR, 6, 1, 2, 0);
    add_op(K_AND, 7, 1, 2, 0);
    add_op(K_SLT, 8, 2, 1, 0);
    add_op(K_SLTU, 9, 2, 1, 0);
    add_op(K_XORI, 10, 1, 0, lcg_next() >> 20);
    add_op(K_ORI, 11, 2, 0, lcg_next() >> 20);
    add_op(K_ANDI, 12, 2, 0, lcg_next() >> 20);
    add_op(K_SLTI, 13, 2, 0, 32'h005);
    add_op(K_SLTIU, 14, 2, 0, 32'h005);
    add_op(K_AUIPC, 15, 0, 0, lcg_next() >> 12);
    add_op(K_ADDI, 0, 1, 0, 32'h005);
    add_op(K_ADD, 16, 0, 1, 0);
    add_op(K_JAL, 17, 0, 0, 32'd8);
    // skipped by the jump
    add_op(K_ADDI, 18, 0, 0, 32'h001);
    add_op(K_ADDI, 19, 17, 0, 32'h000);
    add_op(K_EBREAK, 0, 0, 0, 0);
    run_model();
    load_program();
    run_and_check(1'b0);

    if (!timed_out) begin
      // second program ends in an unsupported opcode
      op_kind.delete();
      op_rd.delete();
      op_rs1.delete();
      op_rs2.delete();
      op_imm.delete();
      add_op(K_ADDI, 1, 0, 0, lcg_next() >> 20);
      add_op(K_ADD, 2, 1, 1, 0);
      add_op(K_ILL, 0, 0, 0, 0);
      add_op(K_ADDI, 3, 0, 0, 32'h001);
      run_model();
      load_program();
      run_and_check(1'b1);
    end

    $display("error count: %0d", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: mini_rv64.f
+incdir+rtl
rtl/core_pkg.sv
rtl/inst_mem.sv
rtl/decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/core_top.sv
dv/core_tb.sv

// File: Makefile
# Verilator build for mini_rv64

VERILATOR ?= verilator
TOP       ?= core_tb
FLAGS     ?= --timing
FILELIST  ?= mini_rv64.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) rtl/*.sv rtl/*.svh dv/*.sv
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# output goes to the terminal and the grep decides the exit status
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
